//--- rtl/calc_pkg.sv
`default_nettype none

package calc_pkg;

    localparam int data_width    = 16;                          // Operand and result width
    localparam int digit_width   = 4;                           // One BCD keypad digit
    localparam int add_sub_steps = 4;                           // Adder works a nibble per step
    localparam int mult_steps    = 16;                          // Multiplier works a bit per step
    localparam int nibble_width  = data_width / add_sub_steps;  // Adder slice width

    // Keypad operator codes
    typedef enum logic [1:0] {
        op_add = 2'b00,
        op_sub = 2'b01,
        op_mul = 2'b11
    } calc_op_t;

    // One job for an arithmetic unit
    typedef struct packed {
        logic [data_width-1:0] operand_a;   // First operand, multiplicand
        logic [data_width-1:0] operand_b;   // Second operand, multiplier
        logic                  subtract;    // Adder only
    } unit_req_t;

    // Unit answer, valid with finish
    typedef struct packed {
        logic [data_width-1:0] result;
    } unit_resp_t;

endpackage

`default_nettype wire

//--- rtl/calc_control.sv
`timescale 1ns/1ps
`default_nettype none

module calc_control import calc_pkg::*; (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic                   key_valid,     // Digit strobe
    input  logic [digit_width-1:0] key_digit,     // 0 to 9
    input  logic                   op_valid,      // Operator strobe
    input  calc_op_t               op,
    input  logic                   equal_valid,   // Equal strobe
    input  logic                   add_finish,
    input  logic                   mul_finish,
    input  unit_resp_t             resp_add,
    input  unit_resp_t             resp_mul,
    output unit_req_t              req,           // Shared by both units
    output logic                   add_start,
    output logic                   mul_start,
    output logic                   complete,      // One cycle per result
    output logic [data_width-1:0]  result         // Held until next complete
);

    typedef enum logic [2:0] {
        get_first   = 3'b000,   // Building operand a
        get_second  = 3'b001,   // Building operand b
        dispatch    = 3'b010,   // Start strobe to one unit
        wait_unit   = 3'b011,   // Unit busy
        show_result = 3'b100    // Complete strobe
    } state_t;

    state_t                state_q;
    state_t                state_d;
    calc_op_t              op_q;            // Latched operator
    logic [data_width-1:0] operand_a_q;
    logic [data_width-1:0] operand_b_q;
    logic                  use_mul;         // Job goes to multiplier
    logic                  unit_finish;     // Finish of the started unit
    logic [data_width-1:0] unit_result;

    // Times ten as value * 8 plus value * 2, then the digit, wrapping at 2^16
    function automatic logic [data_width-1:0] shift_in_digit(
        input logic [data_width-1:0]  value,
        input logic [digit_width-1:0] digit
    );
        return (value << 3) + (value << 1) + {{(data_width - digit_width){1'b0}}, digit};
    endfunction

    assign use_mul     = (op_q == op_mul);
    assign unit_finish = use_mul ? mul_finish : add_finish;         // Only the started one
    assign unit_result = use_mul ? resp_mul.result : resp_add.result;

    // Operands go out straight from the entry registers
    assign req = '{
        operand_a: operand_a_q,
        operand_b: operand_b_q,
        subtract:  (op_q == op_sub)
    };

    assign add_start = (state_q == dispatch) && !use_mul;
    assign mul_start = (state_q == dispatch) && use_mul;
    assign complete  = (state_q == show_result);

    // Key beats op beats equal when strobes collide
    always_comb begin
        state_d = state_q;
        case (state_q)
            get_first: begin
                if (!key_valid && op_valid) begin
                    state_d = get_second;                           // Equal ignored here
                end
            end
            get_second: begin
                if (!key_valid && !op_valid && equal_valid) begin
                    state_d = dispatch;
                end
            end
            dispatch:    state_d = wait_unit;
            wait_unit: begin
                if (unit_finish) begin
                    state_d = show_result;
                end
            end
            show_result: state_d = get_first;
            default:     state_d = get_first;
        endcase
    end

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            state_q     <= get_first;
            op_q        <= op_add;
            operand_a_q <= '0;
            operand_b_q <= '0;
            result      <= '0;
        end else begin
            state_q <= state_d;
            case (state_q)
                get_first: begin
                    if (key_valid) begin
                        operand_a_q <= shift_in_digit(operand_a_q, key_digit);
                    end else if (op_valid) begin
                        op_q        <= op;
                        operand_b_q <= '0;                          // Fresh second operand
                    end
                end
                get_second: begin
                    if (key_valid) begin
                        operand_b_q <= shift_in_digit(operand_b_q, key_digit);
                    end
                end
                wait_unit: begin
                    if (unit_finish) begin
                        result <= unit_result;
                    end
                end
                show_result: begin
                    operand_a_q <= '0;                              // Next entry starts clean
                    operand_b_q <= '0;
                end
                default: ;
            endcase
        end
    end

    // Keypad only ever sends decimal digits while entry is open
    a_key_decimal: assert property (@(posedge clk) disable iff (nRST)
        (key_valid && (state_q == get_first || state_q == get_second))
            |-> (key_digit <= 9))
        else $error("key_digit above 9 accepted");

endmodule

`default_nettype wire

//--- rtl/serial_add_sub.sv
`timescale 1ns/1ps
`default_nettype none

module serial_add_sub import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic       start,
    input  unit_req_t  req,
    output logic       finish,   // Result valid this cycle
    output unit_resp_t resp
);

    typedef logic [$clog2(add_sub_steps)-1:0] step_t;

    logic [data_width-1:0]   a_q;         // Nibbles of a still to add
    logic [data_width-1:0]   b_q;         // Nibbles of b still to add
    logic [data_width-1:0]   sum_q;       // Filled from the top
    logic [data_width-1:0]   b_eff;       // b, inverted for subtract
    logic [data_width-1:0]   a_src;
    logic [data_width-1:0]   b_src;
    logic                    carry_q;
    logic                    carry_in;
    logic [nibble_width:0]   nib_sum;     // Nibble plus carry out
    logic                    busy_q;
    step_t                   step_q;
    logic                    last_step;

    assign b_eff = req.subtract ? ~req.operand_b : req.operand_b;

    // First nibble is taken off the request bus in the start cycle
    assign a_src    = start ? req.operand_a : a_q;
    assign b_src    = start ? b_eff : b_q;
    assign carry_in = start ? req.subtract : carry_q;     // Plus one for two's complement

    assign nib_sum = {1'b0, a_src[nibble_width-1:0]}
                   + {1'b0, b_src[nibble_width-1:0]}
                   + {{nibble_width{1'b0}}, carry_in};

    assign last_step   = busy_q && (step_q == step_t'(add_sub_steps - 1));
    assign resp.result = sum_q;

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            busy_q <= 1'b0;
            step_q <= '0;
            finish <= 1'b0;
        end else begin
            finish <= last_step;                          // Sum complete next cycle
            if (start) begin
                busy_q <= 1'b1;
                step_q <= step_t'(1);                     // Step 0 done at start
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (last_step) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy_q) begin
            a_q     <= a_src >> nibble_width;
            b_q     <= b_src >> nibble_width;
            carry_q <= nib_sum[nibble_width];
            sum_q   <= {nib_sum[nibble_width-1:0], sum_q[data_width-1:nibble_width]};
        end
    end

    // Controller waits for finish before the next job
    a_no_restart: assert property (@(posedge clk) disable iff (nRST)
        start |-> !busy_q)
        else $error("serial_add_sub started while busy");

endmodule

`default_nettype wire

//--- rtl/shift_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module shift_multiplier import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic       start,
    input  unit_req_t  req,      // subtract unused here
    output logic       finish,   // Product valid this cycle
    output unit_resp_t resp
);

    typedef logic [$clog2(mult_steps)-1:0] step_t;

    logic [data_width-1:0] mcand_q;      // Multiplicand, shifted left each step
    logic [data_width-1:0] mplier_q;     // Multiplier, shifted right each step
    logic [data_width-1:0] acc_q;        // Low half of the product
    logic [data_width-1:0] mcand_src;
    logic [data_width-1:0] mplier_src;
    logic [data_width-1:0] acc_src;
    logic [data_width-1:0] partial;      // Shifted multiplicand or zero
    logic                  busy_q;
    step_t                 step_q;
    logic                  last_step;

    // Bit 0 is handled in the start cycle straight from the request
    assign mcand_src  = start ? req.operand_a : mcand_q;
    assign mplier_src = start ? req.operand_b : mplier_q;
    assign acc_src    = start ? '0 : acc_q;

    assign partial = mplier_src[0] ? mcand_src : '0;

    assign last_step   = busy_q && (step_q == step_t'(mult_steps - 1));
    assign resp.result = acc_q;

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            busy_q <= 1'b0;
            step_q <= '0;
            finish <= 1'b0;
        end else begin
            finish <= last_step;
            if (start) begin
                busy_q <= 1'b1;
                step_q <= step_t'(1);
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;           // Wraps to 0 on the last bit
                if (last_step) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // Bits above 15 fall off, product is taken mod 2^16
    always_ff @(posedge clk) begin
        if (start || busy_q) begin
            acc_q    <= acc_src + partial;
            mcand_q  <= mcand_src << 1;
            mplier_q <= mplier_src >> 1;
        end
    end

    // Controller waits for finish before the next job
    a_no_restart: assert property (@(posedge clk) disable iff (nRST)
        start |-> !busy_q)
        else $error("shift_multiplier started while busy");

endmodule

`default_nettype wire

//--- rtl/calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module calc_top import calc_pkg::*; (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic                   key_valid,
    input  logic [digit_width-1:0] key_digit,
    input  logic                   op_valid,
    input  calc_op_t               op,
    input  logic                   equal_valid,
    output logic                   complete,
    output logic [data_width-1:0]  result
);

    unit_req_t  req;          // Fans out to both units
    logic       add_start;
    logic       mul_start;
    logic       add_finish;
    logic       mul_finish;
    unit_resp_t resp_add;
    unit_resp_t resp_mul;

    calc_control u_control (
        .clk         (clk),
        .nRST        (nRST),
        .key_valid   (key_valid),
        .key_digit   (key_digit),
        .op_valid    (op_valid),
        .op          (op),
        .equal_valid (equal_valid),
        .add_finish  (add_finish),
        .mul_finish  (mul_finish),
        .resp_add    (resp_add),
        .resp_mul    (resp_mul),
        .req         (req),
        .add_start   (add_start),
        .mul_start   (mul_start),
        .complete    (complete),
        .result      (result)
    );

    // Add and subtract, 4 cycles
    serial_add_sub u_add_sub (
        .clk    (clk),
        .nRST   (nRST),
        .start  (add_start),
        .req    (req),
        .finish (add_finish),
        .resp   (resp_add)
    );

    // Multiply, 16 cycles
    shift_multiplier u_mult (
        .clk    (clk),
        .nRST   (nRST),
        .start  (mul_start),
        .req    (req),
        .finish (mul_finish),
        .resp   (resp_mul)
    );

endmodule

`default_nettype wire

//--- verif/calc_tb_model.svh
`ifndef CALC_TB_MODEL_SVH
`define CALC_TB_MODEL_SVH

// Keypad entry, operand * 10 + digit kept to 16 bits
function automatic logic [data_width-1:0] model_enter_digit(
    input logic [data_width-1:0]  value,
    input logic [digit_width-1:0] digit
);
    logic [31:0] full;                          // Wide enough for 65535 * 10 + 9
    full = 32'(value) * 32'd10 + 32'(digit);
    return full[data_width-1:0];                // Wrap at 2^16
endfunction

// Expected answer of one calculation, unsigned mod 2^16
function automatic logic [data_width-1:0] model_calc(
    input calc_op_t              o,
    input logic [data_width-1:0] a,
    input logic [data_width-1:0] b
);
    logic [31:0] full;
    case (o)
        op_add:  full = 32'(a) + 32'(b);
        op_sub:  full = 32'(a) - 32'(b);        // Borrow wraps into the low half
        op_mul:  full = 32'(a) * 32'(b);        // Fits 32 bits, low half kept
        default: full = '0;
    endcase
    return full[data_width-1:0];
endfunction

// Compare one observed value against its expected value
task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
        $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
        $display("test failed");
        $fatal(1, "value mismatch in %s", name);
    end
endtask

`endif

//--- verif/calc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module calc_tb import calc_pkg::*; ();

    localparam int num_tests      = 300;
    localparam int entry_cycles   = 40;     // Early equal, 12 digits, op, equal, gaps
    localparam int compute_cycles = 18;     // Multiply is the long one
    localparam int slack_cycles   = 8;
    localparam int timeout_cycles = num_tests * (entry_cycles + compute_cycles + slack_cycles);
    localparam int add_latency    = 6;      // Equal to complete for add and subtract
    localparam int mul_latency    = 18;     // Equal to complete for multiply

    logic                   clk;
    logic                   nRST;
    logic                   key_valid;
    logic [digit_width-1:0] key_digit;
    logic                   op_valid;
    calc_op_t               op;
    logic                   equal_valid;
    logic                   complete;
    logic [data_width-1:0]  result;
    int                     cycle_count = 0;

    `include "calc_tb_model.svh"

    calc_top DUT (
        .clk         (clk),
        .nRST        (nRST),
        .key_valid   (key_valid),
        .key_digit   (key_digit),
        .op_valid    (op_valid),
        .op          (op),
        .equal_valid (equal_valid),
        .complete    (complete),
        .result      (result)
    );

    always #10 clk = ~clk;                  // 20 ns period

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d cycles, complete never arrived", timeout_cycles);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    task automatic clear_inputs();
        key_valid   = 1'b0;
        key_digit   = '0;
        op_valid    = 1'b0;
        op          = op_add;
        equal_valid = 1'b0;
    endtask

    // One entry cycle with no result allowed
    task automatic drive_cycle(input logic kv, input logic [digit_width-1:0] kd,
                               input logic ov, input calc_op_t o, input logic ev);
        @(negedge clk);
        check_value("no complete during entry", 0, int'(complete));
        key_valid   = kv;
        key_digit   = kd;
        op_valid    = ov;
        op          = o;
        equal_valid = ev;
    endtask

    task automatic idle_gap();
        if ($urandom_range(1) == 1) begin
            drive_cycle(1'b0, '0, 1'b0, op_add, 1'b0);
        end
    endtask

    // Random strobes the busy controller must drop
    task automatic drive_junk();
        key_valid   = 1'($urandom_range(1));
        key_digit   = 4'($urandom_range(9));
        op_valid    = 1'($urandom_range(1));
        op          = op_sub;
        equal_valid = 1'($urandom_range(1));
    endtask

    // 0 to 6 digits including zeros
    task automatic enter_operand(output logic [data_width-1:0] value);
        int                     n;
        logic [digit_width-1:0] d;
        value = '0;
        n     = $urandom_range(6);
        repeat (n) begin
            d = 4'($urandom_range(9));
            drive_cycle(1'b1, d, 1'b0, op_add, 1'b0);
            value = model_enter_digit(value, d);
            idle_gap();
        end
    endtask

    task automatic run_calculation(input int idx);
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        logic [data_width-1:0] expected;
        calc_op_t              o;
        int                    latency;
        string                 name;
        name = $sformatf("test %0d", idx);
        if ($urandom_range(3) == 0) begin
            drive_cycle(1'b0, '0, 1'b0, op_add, 1'b1);          // Equal before any op
            repeat (3) drive_cycle(1'b0, '0, 1'b0, op_add, 1'b0);
        end
        enter_operand(a);
        case ($urandom_range(2))
            0:       o = op_add;
            1:       o = op_sub;
            default: o = op_mul;
        endcase
        drive_cycle(1'b0, '0, 1'b1, o, 1'b0);
        idle_gap();
        enter_operand(b);
        drive_cycle(1'b0, '0, 1'b0, op_add, 1'b1);
        expected = model_calc(o, a, b);
        latency  = (o == op_mul) ? mul_latency : add_latency;
        for (int k = 1; k <= latency; k++) begin
            @(negedge clk);
            check_value({name, " complete latency"}, (k == latency) ? 1 : 0, int'(complete));
            if (k < latency) begin
                drive_junk();                                   // Controller is busy
            end else begin
                clear_inputs();
            end
        end
        check_value({name, " result"}, int'(expected), int'(result));
    endtask

    initial begin
        void'($urandom(32'h5adc));
        clk        = 1'b0;
        nRST       = 1'b1;
        clear_inputs();
        repeat (8) begin
            @(negedge clk);
            check_value("complete in reset", 0, int'(complete));
        end
        nRST = 1'b0;                                            // Released on a falling edge
        check_value("result after reset", 0, int'(result));
        for (int i = 0; i < num_tests; i++) begin
            run_calculation(i);
        end
        @(negedge clk);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+verif
rtl/calc_pkg.sv
rtl/calc_control.sv
rtl/serial_add_sub.sv
rtl/shift_multiplier.sv
rtl/calc_top.sv
verif/calc_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module calc_tb \
    -Mdir obj_dir -o calc_sim \
    -f sources.f

# Simulator status is not trusted, the log decides
./obj_dir/calc_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi
